/* Makefile */
# Verilator build and run of the FIR filter testbench

VERILATOR ?= verilator
TOP       ?= tb_fir
FILELIST  ?= fir_filter.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "result: FAIL"; exit 1; \
	elif ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "result: FAIL, run ended without a pass line"; exit 1; \
	else \
		echo "result: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* fir_filter.f */
rtl/fir_pkg.sv
rtl/sp_ram.sv
rtl/fir_mac.sv
rtl/axil_regs.sv
rtl/fir_engine.sv
rtl/fir_top.sv
verification/fir_sva.sv
verification/tb_fir.sv

/* rtl/axil_regs.sv */
`timescale 1ns/10ps

module axil_regs (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           awvalid,
    output logic           awready,
    input  fir_pkg::addr_t awaddr,
    input  logic           wvalid,
    output logic           wready,
    input  fir_pkg::data_t wdata,
    input  logic           arvalid,
    output logic           arready,
    input  fir_pkg::addr_t araddr,
    output logic           rvalid,
    input  logic           rready,
    output fir_pkg::data_t rdata,
    output logic           ap_start,
    output fir_pkg::data_t data_length,
    input  logic           run_done,
    input  logic           engine_busy,
    input  fir_pkg::idx_t  tap_idx,
    output fir_pkg::data_t tap_rdata
);

    typedef enum logic [2:0] {
        wr_init, wr_off, wr_both, wr_need_addr, wr_need_data, wr_commit
    } wr_state_t;

    wr_state_t      wr_state, wr_nxt;
    fir_pkg::addr_t aw_q, ar_q;
    fir_pkg::addr_t aw_off, ar_off;
    fir_pkg::data_t w_q, ctrl_word;
    fir_pkg::idx_t  mem_idx;
    logic           ap_done, ap_idle;
    logic           wr_open, aw_hs, w_hs, ar_hs, ar_pend, commit;
    logic           hit_ctrl, hit_len, hit_tap, ctrl_clr, tap_we;

    // no new writes once a run is requested
    assign wr_open = ap_idle && !ap_start;
    assign awready = (wr_state == wr_both || wr_state == wr_need_addr) && wr_open;
    assign wready  = (wr_state == wr_both || wr_state == wr_need_data) && wr_open;
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    assign commit  = (wr_state == wr_commit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= wr_init;
        end else begin
            wr_state <= wr_nxt;
        end
    end

    always_comb begin
        wr_nxt = wr_state;
        case (wr_state)
            wr_init, wr_off: wr_nxt = wr_open ? wr_both : wr_off;
            wr_both: begin
                if (!wr_open)           wr_nxt = wr_off;
                else if (aw_hs && w_hs) wr_nxt = wr_commit;
                else if (aw_hs)         wr_nxt = wr_need_data;
                else if (w_hs)          wr_nxt = wr_need_addr;
            end
            wr_need_addr: begin
                if (!wr_open)   wr_nxt = wr_off; // half a write is dropped
                else if (aw_hs) wr_nxt = wr_commit;
            end
            wr_need_data: begin
                if (!wr_open)  wr_nxt = wr_off;
                else if (w_hs) wr_nxt = wr_commit;
            end
            wr_commit: wr_nxt = wr_both;
            default:   wr_nxt = wr_init;
        endcase
    end

    always_ff @(posedge clk) begin
        if (aw_hs) aw_q <= awaddr;
        if (w_hs)  w_q  <= wdata;
    end

    // address decode of the captured write
    assign hit_ctrl = (aw_q == fir_pkg::reg_ctrl);
    assign hit_len  = (aw_q == fir_pkg::reg_len);
    assign hit_tap  = (aw_q >= fir_pkg::reg_tap_base) && (aw_q < fir_pkg::reg_tap_end);
    assign aw_off   = aw_q - fir_pkg::reg_tap_base;
    assign ar_off   = araddr - fir_pkg::reg_tap_base;

    // tap port, engine first, then write commit, else read address
    assign tap_we = commit && hit_tap && !engine_busy;
    always_comb begin
        if (engine_busy)  mem_idx = tap_idx;
        else if (commit)  mem_idx = aw_off[2 +: fir_pkg::idx_w];
        else              mem_idx = ar_off[2 +: fir_pkg::idx_w];
    end

    sp_ram #(.depth(fir_pkg::num_taps)) u_tap_ram (
        .clk   (clk),
        .en    (1'b1),
        .we    (tap_we),
        .idx   (mem_idx),
        .wdata (w_q),
        .rdata (tap_rdata)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_length <= '0;
        end else if (commit && hit_len) begin
            data_length <= w_q;
        end
    end

    // reading ctrl while done hands the block back to software
    assign ctrl_clr = ar_pend && (ar_q == fir_pkg::reg_ctrl) && ap_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            ap_idle  <= 1'b1;
        end else begin
            if (commit && hit_ctrl)
                ap_start <= w_q[fir_pkg::ctrl_start];
            else if (!ap_idle)
                ap_start <= 1'b0; // engine has taken it
            if (run_done)
                ap_done <= 1'b1;
            else if (ctrl_clr)
                ap_done <= 1'b0;
            if (ctrl_clr)
                ap_idle <= 1'b1;
            else if (ap_start)
                ap_idle <= 1'b0;
        end
    end

    // read side
    assign arready = !(commit || engine_busy || ar_pend);
    assign ar_hs   = arvalid && arready;

    always_ff @(posedge clk) begin
        if (ar_hs) ar_q <= araddr;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_pend <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            ar_pend <= ar_hs;
            if (ar_pend)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_comb begin
        ctrl_word = '0;
        ctrl_word[fir_pkg::ctrl_start] = ap_start;
        ctrl_word[fir_pkg::ctrl_done]  = ap_done;
        ctrl_word[fir_pkg::ctrl_idle]  = ap_idle;
    end

    // second stage, tap word is out of the RAM by now
    always_ff @(posedge clk) begin
        if (ar_pend) begin
            case (ar_q)
                fir_pkg::reg_ctrl: rdata <= ctrl_word;
                fir_pkg::reg_len:  rdata <= data_length;
                default:           rdata <= tap_rdata;
            endcase
        end
    end

endmodule

/* rtl/fir_engine.sv */
`timescale 1ns/10ps

module fir_engine (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           ap_start,
    input  fir_pkg::data_t data_length,
    output logic           run_done,
    input  logic           ss_tvalid,
    output logic           ss_tready,
    input  fir_pkg::data_t ss_tdata,
    output logic           sm_tvalid,
    input  logic           sm_tready,
    output fir_pkg::data_t sm_tdata,
    output logic           sm_tlast,
    output logic           engine_busy,
    output fir_pkg::idx_t  tap_idx,
    input  fir_pkg::data_t tap_rdata,
    output fir_pkg::data_t sample,
    output logic           coef_valid,
    output logic           acc_clear,
    input  fir_pkg::data_t acc
);

    localparam fir_pkg::idx_t last_idx = fir_pkg::idx_t'(fir_pkg::num_taps - 1);
    localparam fir_pkg::idx_t calc_end = fir_pkg::idx_t'(fir_pkg::num_taps);

    typedef enum logic [2:0] {st_idle, st_zero, st_load, st_calc, st_full} state_t;

    state_t         state, state_nxt;
    fir_pkg::idx_t  cnt, wr_ptr, rd_ptr, data_idx;
    fir_pkg::data_t newest, remain, hold, data_rdata, data_wdata;
    logic           out_valid, pend, hold_load;
    logic           x_hs, y_hs, last_held, calc_last, data_en, data_we;

    assign x_hs      = ss_tvalid && ss_tready;
    assign y_hs      = out_valid && sm_tready;
    assign calc_last = (state == st_calc) && (cnt == calc_end);
    // final output is already held or about to be, take no more samples
    assign last_held = (remain == fir_pkg::data_t'(1)) && (out_valid || pend);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            state <= state_nxt;
            cnt   <= (state != state_nxt) ? '0 : cnt + 1'b1;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: if (ap_start) state_nxt = st_zero;
            st_zero: if (cnt == last_idx) state_nxt = st_load;
            st_load: begin
                if (last_held)  state_nxt = st_idle;
                else if (x_hs)  state_nxt = st_calc;
            end
            st_calc: begin
                if (calc_last)
                    state_nxt = (out_valid && !sm_tready) ? st_full : st_load;
            end
            st_full: if (sm_tready) state_nxt = st_load; // old output leaves
            default: state_nxt = st_idle;
        endcase
    end

    // circular buffer, write goes up and read walks back from the newest
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (x_hs) begin
            wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
            rd_ptr <= (wr_ptr == '0) ? last_idx : wr_ptr - 1'b1;
        end else if (state == st_calc) begin
            rd_ptr <= (rd_ptr == '0) ? last_idx : rd_ptr - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (x_hs) newest <= ss_tdata; // used for the first product
    end

    assign data_en    = (state != st_idle);
    assign data_we    = (state == st_zero) || x_hs;
    assign data_wdata = (state == st_load) ? ss_tdata : '0;

    always_comb begin
        case (state)
            st_zero: data_idx = cnt;
            st_load: data_idx = wr_ptr;
            st_calc: data_idx = rd_ptr;
            default: data_idx = '0;
        endcase
    end

    sp_ram #(.depth(fir_pkg::num_taps)) u_data_ram (
        .clk   (clk),
        .en    (data_en),
        .we    (data_we),
        .idx   (data_idx),
        .wdata (data_wdata),
        .rdata (data_rdata)
    );

    // tap k is addressed one cycle ahead of its product
    assign engine_busy = x_hs || ((state == st_calc) && (cnt < last_idx));
    assign tap_idx     = (state == st_load) ? '0 : cnt + 1'b1;
    assign sample      = (cnt == '0) ? newest : data_rdata;
    // zero taps add nothing, skip them
    assign coef_valid  = (state == st_calc) && (cnt < calc_end) && (tap_rdata != '0);
    assign acc_clear   = (state == st_calc) && (cnt == '0);

    // acc settles one cycle after the last compute cycle
    assign hold_load = pend && (!out_valid || sm_tready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend      <= 1'b0;
            out_valid <= 1'b0;
            remain    <= '0;
        end else begin
            if (hold_load)
                pend <= 1'b0;
            else if (calc_last)
                pend <= 1'b1;
            if (hold_load)
                out_valid <= 1'b1;
            else if (y_hs)
                out_valid <= 1'b0;
            if ((state == st_idle) && ap_start)
                remain <= data_length;
            else if (y_hs)
                remain <= remain - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (hold_load) hold <= acc;
    end

    assign ss_tready = (state == st_load) && !last_held;
    assign sm_tvalid = out_valid;
    assign sm_tdata  = hold;
    assign sm_tlast  = out_valid && (remain == fir_pkg::data_t'(1));
    assign run_done  = y_hs && sm_tlast;

endmodule

/* rtl/fir_mac.sv */
`timescale 1ns/10ps

module fir_mac (
    input  logic           clk,
    input  logic           rst_n,
    input  fir_pkg::data_t sample,
    input  fir_pkg::data_t coef,
    input  logic           coef_valid,
    input  logic           acc_clear,
    output fir_pkg::data_t acc
);

    fir_pkg::data_t prod;
    logic           prod_valid;

    // product truncated to the word width
    always_ff @(posedge clk) begin
        prod <= sample * coef;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= coef_valid; // follows the product stage
        end
    end

    // acc holds whenever nothing valid arrives, e.g. during a stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (acc_clear) begin
            acc <= '0;
        end else if (prod_valid) begin
            acc <= acc + prod;
        end
    end

endmodule

/* rtl/fir_pkg.sv */
package fir_pkg;

    // datapath and bus widths
    localparam int data_w   = 32;
    localparam int addr_w   = 12;
    localparam int idx_w    = 4;   // enough for 11 words
    localparam int num_taps = 11;

    typedef logic [data_w-1:0] data_t;
    typedef logic [addr_w-1:0] addr_t;
    typedef logic [idx_w-1:0]  idx_t;

    // register map, byte offsets
    localparam addr_t reg_ctrl     = 12'h000;
    localparam addr_t reg_len      = 12'h010;
    localparam addr_t reg_tap_base = 12'h020;
    // first byte past the last tap
    localparam addr_t reg_tap_end  = reg_tap_base + addr_t'(4 * num_taps);

    // bits of the control register
    localparam int ctrl_start = 0;
    localparam int ctrl_done  = 1;
    localparam int ctrl_idle  = 2;

endpackage

/* rtl/fir_top.sv */
`timescale 1ns/10ps

module fir_top (
    input  logic           clk,
    input  logic           rst_n,
    // axi-lite
    input  logic           awvalid,
    output logic           awready,
    input  fir_pkg::addr_t awaddr,
    input  logic           wvalid,
    output logic           wready,
    input  fir_pkg::data_t wdata,
    input  logic           arvalid,
    output logic           arready,
    input  fir_pkg::addr_t araddr,
    output logic           rvalid,
    input  logic           rready,
    output fir_pkg::data_t rdata,
    // x in
    input  logic           ss_tvalid,
    output logic           ss_tready,
    input  fir_pkg::data_t ss_tdata,
    // y out
    output logic           sm_tvalid,
    input  logic           sm_tready,
    output fir_pkg::data_t sm_tdata,
    output logic           sm_tlast
);

    logic           ap_start, run_done, engine_busy;
    logic           coef_valid, acc_clear;
    fir_pkg::data_t data_length, tap_rdata, sample, acc;
    fir_pkg::idx_t  tap_idx;

    axil_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .ap_start    (ap_start),
        .data_length (data_length),
        .run_done    (run_done),
        .engine_busy (engine_busy),
        .tap_idx     (tap_idx),
        .tap_rdata   (tap_rdata)
    );

    fir_engine u_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .ap_start    (ap_start),
        .data_length (data_length),
        .run_done    (run_done),
        .ss_tvalid   (ss_tvalid),
        .ss_tready   (ss_tready),
        .ss_tdata    (ss_tdata),
        .sm_tvalid   (sm_tvalid),
        .sm_tready   (sm_tready),
        .sm_tdata    (sm_tdata),
        .sm_tlast    (sm_tlast),
        .engine_busy (engine_busy),
        .tap_idx     (tap_idx),
        .tap_rdata   (tap_rdata),
        .sample      (sample),
        .coef_valid  (coef_valid),
        .acc_clear   (acc_clear),
        .acc         (acc)
    );

    // coefficient comes straight from the tap RAM
    fir_mac u_mac (
        .clk        (clk),
        .rst_n      (rst_n),
        .sample     (sample),
        .coef       (tap_rdata),
        .coef_valid (coef_valid),
        .acc_clear  (acc_clear),
        .acc        (acc)
    );

endmodule

/* rtl/sp_ram.sv */
`timescale 1ns/10ps

module sp_ram #(
    parameter int depth = fir_pkg::num_taps
) (
    input  logic           clk,
    input  logic           en,
    input  logic           we,
    input  fir_pkg::idx_t  idx,
    input  fir_pkg::data_t wdata,
    output fir_pkg::data_t rdata
);

    fir_pkg::data_t mem [depth];

    // one port, read data registered
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[idx] <= wdata;
            end
            rdata <= mem[idx]; // old word on a write cycle
        end
    end

endmodule

/* verification/fir_sva.sv */
`timescale 1ns/10ps

module fir_sva (
    input logic           clk,
    input logic           rst_n,
    input logic           awready,
    input logic           wready,
    input logic           idle,
    input logic           rvalid,
    input logic           rready,
    input logic           ss_tready,
    input logic           sm_tvalid,
    input logic           sm_tready,
    input fir_pkg::data_t sm_tdata,
    input logic           sm_tlast
);

    int fail_count = 0; // read by the testbench at the end

    // output word frozen while the sink holds off
    a_tdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata))
        else begin
            $error("sm_tdata changed or sm_tvalid dropped during a stall");
            fail_count++;
        end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else begin
            $error("rvalid dropped before rready");
            fail_count++;
        end

    // no register writes while a run owns the block
    a_aw_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (ss_tready || sm_tvalid) |-> !idle && !awready && !wready)
        else begin
            $error("idle set or write channel open while the stream is active");
            fail_count++;
        end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !ss_tready && !sm_tlast)
        else begin
            $error("stream flag high during reset");
            fail_count++;
        end

endmodule

/* verification/tb_fir.sv */
`timescale 1ns/10ps

module tb_fir;

    localparam int          num_rows  = 18;
    localparam int          max_len   = 64;
    localparam int          drive_dly = 2;
    localparam logic [31:0] lfsr_seed = 32'd72280;
    localparam logic [31:0] lfsr_poly = 32'h8020_0003;

    // expected control words with one flag each
    localparam fir_pkg::data_t idle_word = fir_pkg::data_t'(1) << fir_pkg::ctrl_idle;
    localparam fir_pkg::data_t done_word = fir_pkg::data_t'(1) << fir_pkg::ctrl_done;
    localparam fir_pkg::data_t go_word   = fir_pkg::data_t'(1) << fir_pkg::ctrl_start;

    typedef struct packed {
        logic [31:0] len;
        logic [31:0] tap_seed;
        logic [31:0] smp_seed;
        logic        throttle; // random sm_tready
    } row_t;

    row_t rows [num_rows] = '{
        '{32'd1,  32'h0000_1234, 32'h0000_4321, 1'b0},
        '{32'd2,  32'h0000_00a5, 32'h0000_5a00, 1'b0},
        '{32'd3,  32'h0001_0001, 32'h0002_0002, 1'b1},
        '{32'd5,  32'h00c0_ffee, 32'h0000_beef, 1'b0},
        '{32'd8,  32'h0000_0777, 32'h0000_0888, 1'b1},
        '{32'd11, 32'h0000_3c3c, 32'h0000_c3c3, 1'b0},
        '{32'd12, 32'h0abc_0000, 32'h0def_0000, 1'b1},
        '{32'd16, 32'h0000_0042, 32'h0000_2400, 1'b0},
        '{32'd20, 32'h0012_3456, 32'h0065_4321, 1'b1},
        '{32'd24, 32'h0000_f00d, 32'h0000_d00f, 1'b0},
        '{32'd30, 32'h0101_0101, 32'h1010_1010, 1'b1},
        '{32'd9,  32'h0000_0003, 32'h0000_0005, 1'b1},
        '{32'd1,  32'h0000_9999, 32'h0000_6666, 1'b1},
        '{32'd13, 32'h7000_0000, 32'h0700_0000, 1'b0},
        '{32'd40, 32'h0000_5555, 32'h0000_aaaa, 1'b1},
        '{32'd7,  32'h0033_0033, 32'h0044_0044, 1'b0},
        '{32'd25, 32'h0000_0e0e, 32'h0000_e0e0, 1'b1},
        '{32'd33, 32'h0fed_cba9, 32'h0123_4567, 1'b1}
    };

    logic           clk;
    logic           rst_n;
    logic           awvalid, awready, wvalid, wready;
    logic           arvalid, arready, rvalid, rready;
    fir_pkg::addr_t awaddr, araddr;
    fir_pkg::data_t wdata, rdata;
    logic           ss_tvalid, ss_tready, sm_tvalid, sm_tready, sm_tlast;
    fir_pkg::data_t ss_tdata, sm_tdata;

    fir_pkg::data_t taps [fir_pkg::num_taps];
    fir_pkg::data_t xs [max_len];
    logic [31:0]    lfsr_state;
    int             cycle_count = 0;
    int             cycle_limit = 0;

    fir_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .ss_tvalid (ss_tvalid),
        .ss_tready (ss_tready),
        .ss_tdata  (ss_tdata),
        .sm_tvalid (sm_tvalid),
        .sm_tready (sm_tready),
        .sm_tdata  (sm_tdata),
        .sm_tlast  (sm_tlast)
    );

    bind fir_top fir_sva u_sva (
        .clk       (clk),
        .rst_n     (rst_n),
        .awready   (awready),
        .wready    (wready),
        .idle      (u_regs.ap_idle),
        .rvalid    (rvalid),
        .rready    (rready),
        .ss_tready (ss_tready),
        .sm_tvalid (sm_tvalid),
        .sm_tready (sm_tready),
        .sm_tdata  (sm_tdata),
        .sm_tlast  (sm_tlast)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_with_failure($sformatf("timeout, run still busy after %0d cycles", cycle_count));
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input fir_pkg::data_t got,
                               input fir_pkg::data_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    // galois form stepped one bit at a time
    function automatic logic lfsr_step();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) lfsr_state = lfsr_state ^ lfsr_poly;
        return out;
    endfunction

    function automatic fir_pkg::data_t lfsr_word();
        fir_pkg::data_t w;
        w = '0;
        for (int i = 0; i < fir_pkg::data_w; i++) begin
            w = {w[fir_pkg::data_w-2:0], lfsr_step()};
        end
        return w;
    endfunction

    // y[n] = sum h[k]*x[n-k] with zero history before the run
    function automatic fir_pkg::data_t model_y(input int n);
        fir_pkg::data_t y;
        y = '0;
        for (int k = 0; k < fir_pkg::num_taps; k++) begin
            if (n - k >= 0) y = y + taps[k] * xs[n - k];
        end
        return y;
    endfunction

    function automatic fir_pkg::addr_t tap_addr(input int k);
        return fir_pkg::reg_tap_base + fir_pkg::addr_t'(4 * k);
    endfunction

    // address and data offered together and each dropped once taken
    task automatic axil_write(input fir_pkg::addr_t addr, input fir_pkg::data_t data);
        logic aw_done, w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            if (awvalid && awready) aw_done = 1'b1;
            if (wvalid && wready)   w_done  = 1'b1;
            @(posedge clk);
            #(drive_dly);
            if (aw_done) awvalid = 1'b0;
            if (w_done)  wvalid  = 1'b0;
        end
    endtask

    task automatic axil_read(input fir_pkg::addr_t addr, output fir_pkg::data_t data);
        arvalid = 1'b1;
        araddr  = addr;
        do begin
            @(negedge clk);
        end while (!arready);
        @(posedge clk);
        #(drive_dly);
        arvalid = 1'b0;
        do begin
            @(negedge clk);
        end while (!rvalid);
        @(posedge clk);  // rready one cycle late so rvalid has to hold
        #(drive_dly);
        rready = 1'b1;
        @(negedge clk);
        data = rdata;
        @(posedge clk);
        #(drive_dly);
        rready = 1'b0;
    endtask

    task automatic send_samples(input int len);
        for (int i = 0; i < len; i++) begin
            ss_tvalid = 1'b1;
            ss_tdata  = xs[i];
            do begin
                @(negedge clk);
            end while (!ss_tready);
            @(posedge clk);
            #(drive_dly);
        end
        ss_tvalid = 1'b0;
    endtask

    task automatic collect_outputs(input int len, input logic throttle);
        int got;
        got = 0;
        while (got < len) begin
            @(posedge clk);
            #(drive_dly);
            sm_tready = throttle ? lfsr_step() : 1'b1;
            @(negedge clk);
            if (sm_tvalid && sm_tready) begin
                check_value($sformatf("sm_tdata[%0d]", got), sm_tdata, model_y(got));
                check_value($sformatf("sm_tlast[%0d]", got), fir_pkg::data_t'(sm_tlast),
                            fir_pkg::data_t'(got == len - 1));
                got++;
            end
        end
        @(posedge clk);
        #(drive_dly);
        sm_tready = 1'b0;
    endtask

    task automatic run_row(input int r);
        row_t           row;
        fir_pkg::data_t val;
        int             len;
        row = rows[r];
        len = int'(row.len);
        lfsr_state = lfsr_seed ^ row.tap_seed;
        for (int k = 0; k < fir_pkg::num_taps; k++) begin
            taps[k] = lfsr_word();
            axil_write(tap_addr(k), taps[k]);
        end
        axil_write(fir_pkg::reg_len, row.len);
        if (r == 0) begin
            for (int k = 0; k < fir_pkg::num_taps; k++) begin
                axil_read(tap_addr(k), val);
                check_value($sformatf("tap %0d readback", k), val, taps[k]);
            end
            axil_read(fir_pkg::reg_len, val);
            check_value("length readback", val, row.len);
        end
        lfsr_state = lfsr_seed ^ row.smp_seed;
        for (int i = 0; i < len; i++) begin
            xs[i] = lfsr_word();
        end
        axil_write(fir_pkg::reg_ctrl, go_word);
        fork
            send_samples(len);
            collect_outputs(len, row.throttle);
        join
        @(negedge clk);
        check_value("sm_tvalid after last output", fir_pkg::data_t'(sm_tvalid), '0);
        @(posedge clk);
        #(drive_dly);
        axil_read(fir_pkg::reg_ctrl, val);
        check_value("ctrl after run", val, done_word);
        axil_read(fir_pkg::reg_ctrl, val);  // first read handed the block back
        check_value("ctrl after done read", val, idle_word);
    endtask

    initial begin
        fir_pkg::data_t val;
        int             total;
        total = 0;
        for (int r = 0; r < num_rows; r++) begin
            total += int'(rows[r].len);
        end
        cycle_limit = total * 40 + 2000;
        rst_n     = 1'b0;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        ss_tvalid = 1'b0;
        ss_tdata  = '0;
        sm_tready = 1'b0;
        lfsr_state = lfsr_seed;
        repeat (3) @(posedge clk);
        #(drive_dly);
        rst_n = 1'b1;
        @(posedge clk);
        #(drive_dly);
        axil_read(fir_pkg::reg_ctrl, val);
        check_value("ctrl after reset", val, idle_word);
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        if (u_dut.u_sva.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stop_with_failure($sformatf("%0d assertion failures in the bound checker",
                                        u_dut.u_sva.fail_count));
        end
    end

endmodule
